// ==== flist.f ====
hw/cpuTypesPkg.sv
hw/decodeCtlPkg.sv
hw/instrDecoder.sv
hw/issuePairer.sv
hw/decodeStage.sv
verif/decodeStage_properties.sv
verif/decodeStageTb.sv

// ==== hw/cpuTypesPkg.sv ====
package cpuTypesPkg;

    // machine word, used for instructions and addresses
    typedef logic [31:0] word_t;

    // general purpose register number
    typedef logic [4:0] regAddr_t;

    // raw 16-bit immediate as it sits in the instruction
    typedef logic [15:0] imm_t;

    // CP0 register number in the upper five bits, select in the lower three
    typedef logic [7:0] cp0Addr_t;

    localparam regAddr_t REG_ZERO = 5'd0;
    localparam regAddr_t REG_RA   = 5'd31;   // link register for JAL

endpackage

// ==== hw/decodeCtlPkg.sv ====
package decodeCtlPkg;

    typedef logic [5:0] opcode_t;   // opcode and funct fields share this width
    typedef logic [3:0] aluOp_t;
    typedef logic [7:0] ctlBits_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_COP0    = 6'h10;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // funct codes under SPECIAL
    localparam opcode_t FN_SLL  = 6'h00;
    localparam opcode_t FN_JR   = 6'h08;
    localparam opcode_t FN_ADDU = 6'h21;
    localparam opcode_t FN_SUBU = 6'h23;
    localparam opcode_t FN_AND  = 6'h24;
    localparam opcode_t FN_OR   = 6'h25;
    localparam opcode_t FN_XOR  = 6'h26;
    localparam opcode_t FN_SLT  = 6'h2a;

    // rs field under COP0 picks the move direction
    localparam logic [4:0] RS_MF = 5'h00;
    localparam logic [4:0] RS_MT = 5'h04;

    localparam aluOp_t ALU_NONE = 4'd0;
    localparam aluOp_t ALU_ADD  = 4'd1;
    localparam aluOp_t ALU_SUB  = 4'd2;
    localparam aluOp_t ALU_AND  = 4'd3;
    localparam aluOp_t ALU_OR   = 4'd4;
    localparam aluOp_t ALU_XOR  = 4'd5;
    localparam aluOp_t ALU_SLT  = 4'd6;
    localparam aluOp_t ALU_SLL  = 4'd7;
    localparam aluOp_t ALU_LUI  = 4'd8;

    // bit positions inside ctlBits_t
    localparam int CTL_REGWRITE = 0;
    localparam int CTL_MEMREAD  = 1;
    localparam int CTL_MEMWRITE = 2;
    localparam int CTL_BRANCH   = 3;
    localparam int CTL_JUMP     = 4;
    localparam int CTL_CP0WRITE = 5;
    localparam int CTL_CP0READ  = 6;
    localparam int CTL_USEIMM   = 7;

endpackage

// ==== hw/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage #(
    parameter int unsigned PcStep = 4
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   stall,
    input  cpuTypesPkg::word_t     instr0,
    input  cpuTypesPkg::word_t     instr1,
    input  logic                   valid0,
    input  logic                   valid1,
    input  cpuTypesPkg::word_t     pc,
    output logic                   outValid0,
    output logic                   outValid1,
    output cpuTypesPkg::word_t     outPc0,
    output cpuTypesPkg::word_t     outPc1,
    output decodeCtlPkg::ctlBits_t outCtl0,
    output decodeCtlPkg::ctlBits_t outCtl1,
    output decodeCtlPkg::aluOp_t   outAluOp0,
    output decodeCtlPkg::aluOp_t   outAluOp1,
    output cpuTypesPkg::regAddr_t  outSrcA0,
    output cpuTypesPkg::regAddr_t  outSrcA1,
    output cpuTypesPkg::regAddr_t  outSrcB0,
    output cpuTypesPkg::regAddr_t  outSrcB1,
    output cpuTypesPkg::regAddr_t  outDest0,
    output cpuTypesPkg::regAddr_t  outDest1,
    output cpuTypesPkg::imm_t      outImm0,
    output cpuTypesPkg::imm_t      outImm1,
    output cpuTypesPkg::cp0Addr_t  outCp0Addr0,
    output cpuTypesPkg::cp0Addr_t  outCp0Addr1,
    output logic                   outIllegal0,
    output logic                   outIllegal1,
    output logic                   outIsSlot1,
    output logic                   branchMisalign,
    output logic                   pairHazard
);
    import cpuTypesPkg::*;
    import decodeCtlPkg::*;

    ctlBits_t ctl0;
    ctlBits_t ctl1;
    aluOp_t   aluOp0;
    aluOp_t   aluOp1;
    regAddr_t srcA0;
    regAddr_t srcA1;
    regAddr_t srcB0;
    regAddr_t srcB1;
    regAddr_t dest0;
    regAddr_t dest1;
    imm_t     imm0;
    imm_t     imm1;
    cp0Addr_t cp0Addr0;
    cp0Addr_t cp0Addr1;
    logic     illegal0;
    logic     illegal1;

    // slot 0 holds the older instruction at pc
    instrDecoder u_dec0 (
        .valid   (valid0),
        .instr   (instr0),
        .ctl     (ctl0),
        .aluOp   (aluOp0),
        .srcA    (srcA0),
        .srcB    (srcB0),
        .dest    (dest0),
        .imm     (imm0),
        .cp0Addr (cp0Addr0),
        .illegal (illegal0)
    );

    instrDecoder u_dec1 (
        .valid   (valid1),
        .instr   (instr1),
        .ctl     (ctl1),
        .aluOp   (aluOp1),
        .srcA    (srcA1),
        .srcB    (srcB1),
        .dest    (dest1),
        .imm     (imm1),
        .cp0Addr (cp0Addr1),
        .illegal (illegal1)
    );

    issuePairer #(
        .PcStep (PcStep)
    ) u_pair (
        .clk            (clk),
        .rstN           (rstN),
        .stall          (stall),
        .pc             (pc),
        .valid0         (valid0),
        .valid1         (valid1),
        .ctl0           (ctl0),
        .ctl1           (ctl1),
        .aluOp0         (aluOp0),
        .aluOp1         (aluOp1),
        .srcA0          (srcA0),
        .srcA1          (srcA1),
        .srcB0          (srcB0),
        .srcB1          (srcB1),
        .dest0          (dest0),
        .dest1          (dest1),
        .imm0           (imm0),
        .imm1           (imm1),
        .cp0Addr0       (cp0Addr0),
        .cp0Addr1       (cp0Addr1),
        .illegal0       (illegal0),
        .illegal1       (illegal1),
        .outValid0      (outValid0),
        .outValid1      (outValid1),
        .outPc0         (outPc0),
        .outPc1         (outPc1),
        .outCtl0        (outCtl0),
        .outCtl1        (outCtl1),
        .outAluOp0      (outAluOp0),
        .outAluOp1      (outAluOp1),
        .outSrcA0       (outSrcA0),
        .outSrcA1       (outSrcA1),
        .outSrcB0       (outSrcB0),
        .outSrcB1       (outSrcB1),
        .outDest0       (outDest0),
        .outDest1       (outDest1),
        .outImm0        (outImm0),
        .outImm1        (outImm1),
        .outCp0Addr0    (outCp0Addr0),
        .outCp0Addr1    (outCp0Addr1),
        .outIllegal0    (outIllegal0),
        .outIllegal1    (outIllegal1),
        .outIsSlot1     (outIsSlot1),
        .branchMisalign (branchMisalign),
        .pairHazard     (pairHazard)
    );

endmodule

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  logic                   valid,
    input  cpuTypesPkg::word_t     instr,
    output decodeCtlPkg::ctlBits_t ctl,
    output decodeCtlPkg::aluOp_t   aluOp,
    output cpuTypesPkg::regAddr_t  srcA,
    output cpuTypesPkg::regAddr_t  srcB,
    output cpuTypesPkg::regAddr_t  dest,
    output cpuTypesPkg::imm_t      imm,
    output cpuTypesPkg::cp0Addr_t  cp0Addr,
    output logic                   illegal
);
    import cpuTypesPkg::*;
    import decodeCtlPkg::*;

    opcode_t  opcode;
    opcode_t  funct;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        ctl     = '0;
        aluOp   = ALU_NONE;
        srcA    = REG_ZERO;
        srcB    = REG_ZERO;
        dest    = REG_ZERO;   // stays zero unless a register is written
        imm     = '0;
        cp0Addr = '0;
        illegal = 1'b0;
        if (valid) begin
            srcA = rs;
            srcB = rt;
            imm  = instr[15:0];
            case (opcode)
                OP_SPECIAL: begin
                    case (funct)
                        FN_ADDU: aluOp = ALU_ADD;
                        FN_SUBU: aluOp = ALU_SUB;
                        FN_AND:  aluOp = ALU_AND;
                        FN_OR:   aluOp = ALU_OR;
                        FN_XOR:  aluOp = ALU_XOR;
                        FN_SLT:  aluOp = ALU_SLT;
                        FN_SLL:  aluOp = ALU_SLL;
                        FN_JR:   ctl[CTL_JUMP] = 1'b1;
                        default: illegal = 1'b1;
                    endcase
                    // every supported SPECIAL op except JR writes rd
                    if (!illegal && funct != FN_JR) begin
                        ctl[CTL_REGWRITE] = 1'b1;
                        dest = rd;
                    end
                end
                OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                    ctl[CTL_REGWRITE] = 1'b1;
                    ctl[CTL_USEIMM]   = 1'b1;
                    ctl[CTL_MEMREAD]  = (opcode == OP_LW);
                    dest = rt;
                    if (opcode == OP_ORI) aluOp = ALU_OR;
                    else if (opcode == OP_LUI) aluOp = ALU_LUI;
                    else aluOp = ALU_ADD;   // address add for LW
                end
                OP_SW: begin
                    ctl[CTL_MEMWRITE] = 1'b1;
                    ctl[CTL_USEIMM]   = 1'b1;
                    aluOp = ALU_ADD;
                end
                OP_BEQ, OP_BNE: begin
                    ctl[CTL_BRANCH] = 1'b1;
                    aluOp = ALU_SUB;   // compare by subtraction
                end
                OP_J: ctl[CTL_JUMP] = 1'b1;
                OP_JAL: begin
                    ctl[CTL_JUMP]     = 1'b1;
                    ctl[CTL_REGWRITE] = 1'b1;
                    dest = REG_RA;
                end
                OP_COP0: begin
                    if (rs == RS_MF) begin
                        ctl[CTL_REGWRITE] = 1'b1;
                        ctl[CTL_CP0READ]  = 1'b1;
                        dest    = rd;
                        cp0Addr = {rd, instr[2:0]};
                    end else if (rs == RS_MT) begin
                        ctl[CTL_CP0WRITE] = 1'b1;
                        cp0Addr = {rd, instr[2:0]};
                    end else begin
                        illegal = 1'b1;
                    end
                end
                default: illegal = 1'b1;
            endcase
        end
    end

endmodule

// ==== hw/issuePairer.sv ====
`timescale 1ns/1ps

module issuePairer #(
    parameter int unsigned PcStep = 4
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   stall,
    input  cpuTypesPkg::word_t     pc,
    input  logic                   valid0,
    input  logic                   valid1,
    input  decodeCtlPkg::ctlBits_t ctl0,
    input  decodeCtlPkg::ctlBits_t ctl1,
    input  decodeCtlPkg::aluOp_t   aluOp0,
    input  decodeCtlPkg::aluOp_t   aluOp1,
    input  cpuTypesPkg::regAddr_t  srcA0,
    input  cpuTypesPkg::regAddr_t  srcA1,
    input  cpuTypesPkg::regAddr_t  srcB0,
    input  cpuTypesPkg::regAddr_t  srcB1,
    input  cpuTypesPkg::regAddr_t  dest0,
    input  cpuTypesPkg::regAddr_t  dest1,
    input  cpuTypesPkg::imm_t      imm0,
    input  cpuTypesPkg::imm_t      imm1,
    input  cpuTypesPkg::cp0Addr_t  cp0Addr0,
    input  cpuTypesPkg::cp0Addr_t  cp0Addr1,
    input  logic                   illegal0,
    input  logic                   illegal1,
    output logic                   outValid0,
    output logic                   outValid1,
    output cpuTypesPkg::word_t     outPc0,
    output cpuTypesPkg::word_t     outPc1,
    output decodeCtlPkg::ctlBits_t outCtl0,
    output decodeCtlPkg::ctlBits_t outCtl1,
    output decodeCtlPkg::aluOp_t   outAluOp0,
    output decodeCtlPkg::aluOp_t   outAluOp1,
    output cpuTypesPkg::regAddr_t  outSrcA0,
    output cpuTypesPkg::regAddr_t  outSrcA1,
    output cpuTypesPkg::regAddr_t  outSrcB0,
    output cpuTypesPkg::regAddr_t  outSrcB1,
    output cpuTypesPkg::regAddr_t  outDest0,
    output cpuTypesPkg::regAddr_t  outDest1,
    output cpuTypesPkg::imm_t      outImm0,
    output cpuTypesPkg::imm_t      outImm1,
    output cpuTypesPkg::cp0Addr_t  outCp0Addr0,
    output cpuTypesPkg::cp0Addr_t  outCp0Addr1,
    output logic                   outIllegal0,
    output logic                   outIllegal1,
    output logic                   outIsSlot1,
    output logic                   branchMisalign,
    output logic                   pairHazard
);
    import cpuTypesPkg::*;
    import decodeCtlPkg::*;

    logic jump0;
    logic jump1;
    logic misalign;
    logic hazard;
    logic keep1;

    assign jump0 = ctl0[CTL_BRANCH] | ctl0[CTL_JUMP];
    assign jump1 = ctl1[CTL_BRANCH] | ctl1[CTL_JUMP];

    // a younger branch has to wait so it issues together with its delay slot
    assign misalign = valid0 && valid1 && jump1;

    // dest0 is already zero for non-writers, so one compare covers both cases
    assign hazard = valid0 && valid1 && !jump1 && dest0 != REG_ZERO &&
                    (dest0 == srcA1 || dest0 == srcB1);

    assign keep1 = valid1 && !misalign && !hazard;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid0      <= 1'b0;
            outValid1      <= 1'b0;
            outPc0         <= '0;
            outPc1         <= '0;
            outCtl0        <= '0;
            outCtl1        <= '0;
            outAluOp0      <= '0;
            outAluOp1      <= '0;
            outSrcA0       <= '0;
            outSrcA1       <= '0;
            outSrcB0       <= '0;
            outSrcB1       <= '0;
            outDest0       <= '0;
            outDest1       <= '0;
            outImm0        <= '0;
            outImm1        <= '0;
            outCp0Addr0    <= '0;
            outCp0Addr1    <= '0;
            outIllegal0    <= 1'b0;
            outIllegal1    <= 1'b0;
            outIsSlot1     <= 1'b0;
            branchMisalign <= 1'b0;
            pairHazard     <= 1'b0;
        end else if (!stall) begin
            // slot 0 fields come out of the decoder already zeroed when invalid
            outValid0      <= valid0;
            outPc0         <= valid0 ? pc : '0;
            outCtl0        <= ctl0;
            outAluOp0      <= aluOp0;
            outSrcA0       <= srcA0;
            outSrcB0       <= srcB0;
            outDest0       <= dest0;
            outImm0        <= imm0;
            outCp0Addr0    <= cp0Addr0;
            outIllegal0    <= illegal0;
            outValid1      <= keep1;
            outPc1         <= keep1 ? pc + word_t'(PcStep) : '0;
            outCtl1        <= keep1 ? ctl1 : '0;
            outAluOp1      <= keep1 ? aluOp1 : '0;
            outSrcA1       <= keep1 ? srcA1 : '0;
            outSrcB1       <= keep1 ? srcB1 : '0;
            outDest1       <= keep1 ? dest1 : '0;
            outImm1        <= keep1 ? imm1 : '0;
            outCp0Addr1    <= keep1 ? cp0Addr1 : '0;
            outIllegal1    <= keep1 && illegal1;
            outIsSlot1     <= jump0 && keep1;   // slot 1 is the delay slot
            branchMisalign <= misalign;
            pairHazard     <= hazard;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module decodeStageTb -o decodeStageSim

if ! ./obj_dir/decodeStageSim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0

// ==== verif/decodeStageTb.sv ====
`timescale 1ns/1ps

module decodeStageTb;
    import cpuTypesPkg::*;
    import decodeCtlPkg::*;

    localparam int unsigned PcStep = 4;
    localparam int ResetCycles = 5;
    localparam int RunCycles = 2000;
    localparam int TimeoutCycles = RunCycles + 100;   // room for reset and the last edge
    localparam logic [31:0] Seed = 32'h6539_da4a;

    // control flag masks built from the bit positions
    localparam ctlBits_t RegWr  = ctlBits_t'(1) << CTL_REGWRITE;
    localparam ctlBits_t MemRd  = ctlBits_t'(1) << CTL_MEMREAD;
    localparam ctlBits_t MemWr  = ctlBits_t'(1) << CTL_MEMWRITE;
    localparam ctlBits_t Br     = ctlBits_t'(1) << CTL_BRANCH;
    localparam ctlBits_t Jmp    = ctlBits_t'(1) << CTL_JUMP;
    localparam ctlBits_t Cp0Wr  = ctlBits_t'(1) << CTL_CP0WRITE;
    localparam ctlBits_t Cp0Rd  = ctlBits_t'(1) << CTL_CP0READ;
    localparam ctlBits_t UseImm = ctlBits_t'(1) << CTL_USEIMM;

    // opcode in the upper six bits, funct or COP0 rs below; the last four are illegal
    localparam int NumOps = 23;
    localparam logic [11:0] OpTable [NumOps] = '{
        {OP_SPECIAL, FN_ADDU}, {OP_SPECIAL, FN_SUBU}, {OP_SPECIAL, FN_AND},
        {OP_SPECIAL, FN_OR}, {OP_SPECIAL, FN_XOR}, {OP_SPECIAL, FN_SLT},
        {OP_SPECIAL, FN_SLL}, {OP_SPECIAL, FN_JR}, {OP_ADDIU, 6'h00},
        {OP_ORI, 6'h00}, {OP_LUI, 6'h00}, {OP_LW, 6'h00}, {OP_SW, 6'h00},
        {OP_BEQ, 6'h00}, {OP_BNE, 6'h00}, {OP_J, 6'h00}, {OP_JAL, 6'h00},
        {OP_COP0, 1'b0, RS_MF}, {OP_COP0, 1'b0, RS_MT},
        {OP_SPECIAL, 6'h3f}, {6'h3f, 6'h00}, {OP_COP0, 6'h10}, {6'h01, 6'h00}
    };

    typedef struct packed {
        ctlBits_t ctl;
        aluOp_t   aluOp;
        regAddr_t srcA;
        regAddr_t srcB;
        regAddr_t dest;
        imm_t     imm;
        cp0Addr_t cp0Addr;
        logic     illegal;
    } decodedSlot_t;

    typedef struct packed {
        logic         valid0;
        logic         valid1;
        word_t        pc0;
        word_t        pc1;
        decodedSlot_t slot0;
        decodedSlot_t slot1;
        logic         isSlot1;
        logic         misalign;
        logic         hazard;
    } stageOut_t;

    logic clk;
    logic rstN;
    logic stall;
    logic valid0;
    logic valid1;
    word_t instr0;
    word_t instr1;
    word_t pc;
    logic outValid0;
    logic outValid1;
    word_t outPc0;
    word_t outPc1;
    ctlBits_t outCtl0;
    ctlBits_t outCtl1;
    aluOp_t outAluOp0;
    aluOp_t outAluOp1;
    regAddr_t outSrcA0;
    regAddr_t outSrcA1;
    regAddr_t outSrcB0;
    regAddr_t outSrcB1;
    regAddr_t outDest0;
    regAddr_t outDest1;
    imm_t outImm0;
    imm_t outImm1;
    cp0Addr_t outCp0Addr0;
    cp0Addr_t outCp0Addr1;
    logic outIllegal0;
    logic outIllegal1;
    logic outIsSlot1;
    logic branchMisalign;
    logic pairHazard;

    logic [31:0] rngState;
    stageOut_t expQ[$];   // one entry per rising edge still to be checked
    stageOut_t lastExp;
    int cycleCount = 0;

    decodeStage #(.PcStep(PcStep)) u_decodeStage (.*);

    bind issuePairer decodeStage_properties u_props (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic word_t makeInstr();
        logic [31:0] r;
        logic [31:0] f;
        logic [11:0] entry;
        logic [5:0]  op;
        logic [5:0]  sel;
        regAddr_t    rs;
        regAddr_t    rt;
        regAddr_t    rd;
        r = nextRand();
        f = nextRand();
        entry = OpTable[int'(r % 32'(NumOps))];
        op = entry[11:6];
        sel = entry[5:0];
        rs = {2'b00, f[2:0]};   // registers 0 to 7 only so that pairs collide often
        rt = {2'b00, f[5:3]};
        rd = {2'b00, f[8:6]};
        if (op == OP_SPECIAL)
            return {op, rs, rt, rd, f[13:9], sel};
        else if (op == OP_COP0)
            return {op, sel[4:0], rt, rd, 8'h00, f[11:9]};
        else
            return {op, rs, rt, f[24:9]};
    endfunction

    function automatic decodedSlot_t decodeModel(input logic v, input word_t ins);
        decodedSlot_t d;
        ctlBits_t     ctlV;
        aluOp_t       aluV;
        regAddr_t     dst;
        regAddr_t     rs;
        regAddr_t     rt;
        regAddr_t     rd;
        logic [5:0]   op;
        logic [5:0]   fn;
        logic         bad;
        d = '0;
        ctlV = '0;
        aluV = ALU_NONE;
        dst = 5'd0;
        bad = 1'b0;
        op = ins[31:26];
        fn = ins[5:0];
        rs = ins[25:21];
        rt = ins[20:16];
        rd = ins[15:11];
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_ADDU: {ctlV, aluV, dst} = {RegWr, ALU_ADD, rd};
                    FN_SUBU: {ctlV, aluV, dst} = {RegWr, ALU_SUB, rd};
                    FN_AND:  {ctlV, aluV, dst} = {RegWr, ALU_AND, rd};
                    FN_OR:   {ctlV, aluV, dst} = {RegWr, ALU_OR, rd};
                    FN_XOR:  {ctlV, aluV, dst} = {RegWr, ALU_XOR, rd};
                    FN_SLT:  {ctlV, aluV, dst} = {RegWr, ALU_SLT, rd};
                    FN_SLL:  {ctlV, aluV, dst} = {RegWr, ALU_SLL, rd};
                    FN_JR:   {ctlV, aluV, dst} = {Jmp, ALU_NONE, 5'd0};
                    default: bad = 1'b1;
                endcase
            end
            OP_ADDIU: {ctlV, aluV, dst} = {RegWr | UseImm, ALU_ADD, rt};
            OP_ORI:   {ctlV, aluV, dst} = {RegWr | UseImm, ALU_OR, rt};
            OP_LUI:   {ctlV, aluV, dst} = {RegWr | UseImm, ALU_LUI, rt};
            OP_LW:    {ctlV, aluV, dst} = {RegWr | UseImm | MemRd, ALU_ADD, rt};
            OP_SW:    {ctlV, aluV, dst} = {MemWr | UseImm, ALU_ADD, 5'd0};
            OP_BEQ:   {ctlV, aluV, dst} = {Br, ALU_SUB, 5'd0};
            OP_BNE:   {ctlV, aluV, dst} = {Br, ALU_SUB, 5'd0};
            OP_J:     {ctlV, aluV, dst} = {Jmp, ALU_NONE, 5'd0};
            OP_JAL:   {ctlV, aluV, dst} = {Jmp | RegWr, ALU_NONE, 5'd31};
            OP_COP0: begin
                if (rs == RS_MF) begin
                    {ctlV, aluV, dst} = {RegWr | Cp0Rd, ALU_NONE, rd};
                    d.cp0Addr = {rd, ins[2:0]};
                end else if (rs == RS_MT) begin
                    ctlV = Cp0Wr;
                    d.cp0Addr = {rd, ins[2:0]};
                end else begin
                    bad = 1'b1;
                end
            end
            default: bad = 1'b1;
        endcase
        if (v) begin
            d.ctl = ctlV;
            d.aluOp = aluV;
            d.srcA = rs;
            d.srcB = rt;
            d.dest = dst;
            d.imm = ins[15:0];
            d.illegal = bad;
        end else begin
            d = '0;   // an empty slot decodes to all zero
        end
        return d;
    endfunction

    function automatic stageOut_t pairModel(input logic v0, input logic v1, input word_t pcIn,
                                            input decodedSlot_t d0, input decodedSlot_t d1);
        stageOut_t o;
        logic      j0;
        logic      j1;
        logic      keep;
        o = '0;
        j0 = d0.ctl[CTL_BRANCH] || d0.ctl[CTL_JUMP];
        j1 = d1.ctl[CTL_BRANCH] || d1.ctl[CTL_JUMP];
        o.misalign = v0 && v1 && j1;
        o.hazard = v0 && v1 && !o.misalign && d0.dest != 5'd0 &&
                   (d0.dest == d1.srcA || d0.dest == d1.srcB);
        keep = v1 && !o.misalign && !o.hazard;
        o.valid0 = v0;
        o.pc0 = v0 ? pcIn : '0;
        o.slot0 = d0;
        o.valid1 = keep;
        if (keep) begin
            o.pc1 = pcIn + word_t'(PcStep);
            o.slot1 = d1;
        end
        o.isSlot1 = j0 && keep;   // the kept younger one is the delay slot
        return o;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else failRun($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic compareOutputs();
        stageOut_t e;
        if (expQ.size() == 0) begin
            failRun("no expected value was queued for this clock edge");
        end else begin
            e = expQ.pop_front();
            checkField("outValid0", 32'(outValid0), 32'(e.valid0));
            checkField("outValid1", 32'(outValid1), 32'(e.valid1));
            checkField("outPc0", outPc0, e.pc0);
            checkField("outPc1", outPc1, e.pc1);
            checkField("outCtl0", 32'(outCtl0), 32'(e.slot0.ctl));
            checkField("outCtl1", 32'(outCtl1), 32'(e.slot1.ctl));
            checkField("outAluOp0", 32'(outAluOp0), 32'(e.slot0.aluOp));
            checkField("outAluOp1", 32'(outAluOp1), 32'(e.slot1.aluOp));
            checkField("outSrcA0", 32'(outSrcA0), 32'(e.slot0.srcA));
            checkField("outSrcA1", 32'(outSrcA1), 32'(e.slot1.srcA));
            checkField("outSrcB0", 32'(outSrcB0), 32'(e.slot0.srcB));
            checkField("outSrcB1", 32'(outSrcB1), 32'(e.slot1.srcB));
            checkField("outDest0", 32'(outDest0), 32'(e.slot0.dest));
            checkField("outDest1", 32'(outDest1), 32'(e.slot1.dest));
            checkField("outImm0", 32'(outImm0), 32'(e.slot0.imm));
            checkField("outImm1", 32'(outImm1), 32'(e.slot1.imm));
            checkField("outCp0Addr0", 32'(outCp0Addr0), 32'(e.slot0.cp0Addr));
            checkField("outCp0Addr1", 32'(outCp0Addr1), 32'(e.slot1.cp0Addr));
            checkField("outIllegal0", 32'(outIllegal0), 32'(e.slot0.illegal));
            checkField("outIllegal1", 32'(outIllegal1), 32'(e.slot1.illegal));
            checkField("outIsSlot1", 32'(outIsSlot1), 32'(e.isSlot1));
            checkField("branchMisalign", 32'(branchMisalign), 32'(e.misalign));
            checkField("pairHazard", 32'(pairHazard), 32'(e.hazard));
        end
    endtask

    task automatic applyCycle();
        logic [31:0] r;
        logic [31:0] pcRand;
        stageOut_t   nextExp;
        r = nextRand();
        pcRand = nextRand();
        stall = (r[2:0] == 3'd0);   // about one cycle in eight
        valid0 = (r[5:3] != 3'd0);
        valid1 = (r[8:6] != 3'd0);
        pc = {pcRand[31:2], 2'b00};
        instr0 = makeInstr();
        instr1 = makeInstr();
        if (stall)
            nextExp = lastExp;
        else
            nextExp = pairModel(valid0, valid1, pc, decodeModel(valid0, instr0),
                                decodeModel(valid1, instr1));
        expQ.push_back(nextExp);
        lastExp = nextExp;
    endtask

    // outputs are checked one step after each rising edge
    always begin
        @(posedge clk);
        #1;
        compareOutputs();
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles)
            failRun("timeout because the run did not finish before the cycle limit");
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        stall = 1'b0;
        valid0 = 1'b0;
        valid1 = 1'b0;
        instr0 = '0;
        instr1 = '0;
        pc = '0;
        rngState = Seed;
        lastExp = '0;
        repeat (ResetCycles) expQ.push_back('0);   // everything reads zero under reset
        repeat (ResetCycles) @(negedge clk);
        rstN = 1'b1;
        repeat (RunCycles) begin
            applyCycle();
            @(negedge clk);
        end
        if (expQ.size() != 0) begin
            failRun("expected values were left unchecked at the end of the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== verif/decodeStage_properties.sv ====
`timescale 1ns/1ps

module decodeStage_properties (
    input logic                   clk,
    input logic                   rstN,
    input logic                   stall,
    input logic                   outValid0,
    input logic                   outValid1,
    input cpuTypesPkg::word_t     outPc0,
    input cpuTypesPkg::word_t     outPc1,
    input decodeCtlPkg::ctlBits_t outCtl0,
    input decodeCtlPkg::ctlBits_t outCtl1,
    input decodeCtlPkg::aluOp_t   outAluOp0,
    input decodeCtlPkg::aluOp_t   outAluOp1,
    input cpuTypesPkg::regAddr_t  outSrcA0,
    input cpuTypesPkg::regAddr_t  outSrcA1,
    input cpuTypesPkg::regAddr_t  outSrcB0,
    input cpuTypesPkg::regAddr_t  outSrcB1,
    input cpuTypesPkg::regAddr_t  outDest0,
    input cpuTypesPkg::regAddr_t  outDest1,
    input cpuTypesPkg::imm_t      outImm0,
    input cpuTypesPkg::imm_t      outImm1,
    input cpuTypesPkg::cp0Addr_t  outCp0Addr0,
    input cpuTypesPkg::cp0Addr_t  outCp0Addr1,
    input logic                   outIllegal0,
    input logic                   outIllegal1,
    input logic                   outIsSlot1,
    input logic                   branchMisalign,
    input logic                   pairHazard
);

    // the branch rule wins, so both drop reasons never show together
    flagsExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(branchMisalign && pairHazard))
        else $error("branchMisalign and pairHazard are high together");

    // dropping slot 1 only happens when an older instruction is present
    flagsNeedSlot0: assert property (@(posedge clk) disable iff (!rstN)
        (branchMisalign || pairHazard) |-> outValid0)
        else $error("drop flag raised without a valid slot 0");

    holdOnStall: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable({outValid0, outValid1, outPc0, outPc1, outCtl0, outCtl1,
                           outAluOp0, outAluOp1, outSrcA0, outSrcA1,
                           outSrcB0, outSrcB1, outDest0, outDest1,
                           outImm0, outImm1, outCp0Addr0, outCp0Addr1,
                           outIllegal0, outIllegal1, outIsSlot1,
                           branchMisalign, pairHazard}))
        else $error("registered outputs changed while stall was high");

endmodule
